// ==== files.f ====
+incdir+verif
hdl/fetch_pkg.sv
hdl/line_bus_pkg.sv
hdl/line_requester.sv
hdl/line_queue.sv
hdl/inst_select.sv
hdl/fetch_frontend.sv
verif/line_slave.sv
verif/tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  -f files.f \
  --top-module tb_fetch \
  -o sim_fetch

./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== verif/mem_model.svh ====
// ====================
// instruction memory contents
// ====================

localparam logic [31:0] LFSR_SEED = 32'h3077179c;

// lines in this byte range answer with SLVERR
localparam logic [31:0] ERR_LO = 32'h8000_1000;
localparam logic [31:0] ERR_HI = 32'h8000_103f;

// galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  logic [31:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

// word stored at byte address a with one LFSR step per bit
function automatic logic [31:0] word_hash(input logic [31:0] a);
  logic [31:0] s;
  logic [31:0] w;
  s = a ^ LFSR_SEED;
  if (s == 32'h0) begin
    s = 32'h1;
  end
  for (int i = 0; i < 32; i++) begin
    s = lfsr_step(s);
    w[i] = s[0];
  end
  return w;
endfunction

function automatic logic [127:0] line_data(input logic [31:0] a);
  logic [31:0] base;
  base = {a[31:4], 4'b0000};
  return {word_hash(base + 32'd12), word_hash(base + 32'd8),
          word_hash(base + 32'd4), word_hash(base)};
endfunction

function automatic logic in_err_window(input logic [31:0] a);
  return (a >= ERR_LO) && (a <= ERR_HI);
endfunction

// ==== verif/tb_fetch.sv ====
`timescale 1ns/10ps

module tb_fetch;

  `include "mem_model.svh"

  // roughly 110 lines at up to 9 cycles each, a slow read, resets, plus margin
  localparam int CYCLE_LIMIT = 4000;
  localparam logic [31:0] START_PC = 32'h8000_0000;
  localparam logic [31:0] JUMP_PC = 32'h8000_0408;

  logic                  clk;
  logic                  rst_n;
  logic                  flush;
  logic                  slow;
  fetch_pkg::pc_t        pc;
  line_bus_pkg::ar_req_t ar;
  logic                  ar_ready;
  line_bus_pkg::r_rsp_t  r;
  logic                  r_ready;
  logic                  inst_valid;
  logic [31:0]           inst;
  logic                  inst_fault;

  int          cycles;
  int          errors;
  int          checks;
  int          tests;
  logic [31:0] ar_log[$];

  fetch_frontend dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush),
    .pc_i         (pc),
    .ar_o         (ar),
    .ar_ready_i   (ar_ready),
    .r_i          (r),
    .r_ready_o    (r_ready),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .inst_fault_o (inst_fault)
  );

  line_slave u_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .slow_i     (slow),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_ready_i  (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================
  // monitors
  // ====================

  // addresses accepted by the memory are logged before the edge that takes them
  always @(negedge clk) begin
    if (!rst_n && ar.valid && ar_ready) begin
      ar_log.push_back(ar.addr);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  // ====================
  // helpers
  // ====================

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic apply_reset(input logic slow_read);
    @(posedge clk);
    rst_n <= 1'b1;
    flush <= 1'b0;
    slow <= slow_read;
    pc <= START_PC;
    repeat (10) @(posedge clk);
    rst_n <= 1'b0;
    ar_log.delete();
  endtask

  task automatic wait_inst_valid;
    @(negedge clk);
    while (!inst_valid) begin
      @(negedge clk);
    end
  endtask

  task automatic jump_to(input logic [31:0] target);
    @(posedge clk);
    flush <= 1'b1;
    pc <= target;
    slow <= 1'b0;
    ar_log.delete();
    @(posedge clk);
    flush <= 1'b0;
  endtask

  // step pc by 4 and check each instruction as it becomes valid
  task automatic run_pcs(input logic [31:0] first, input int count);
    logic [31:0] a;
    for (int i = 0; i < count; i++) begin
      a = first + 32'(4 * i);
      @(posedge clk);
      pc <= a;
      wait_inst_valid();
      if (!in_err_window(a)) begin
        compare(inst, word_hash(a), $sformatf("instruction at pc %h", a));
      end
      compare(32'(inst_fault), 32'(in_err_window(a)), $sformatf("fault at pc %h", a));
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // ====================
  // tests
  // ====================

  task automatic test_reset;
    int e0;
    e0 = errors;
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    compare(32'(ar.valid), 32'h0, "ar valid during reset");
    compare(32'(r_ready), 32'h0, "r_ready during reset");
    compare(32'(inst_valid), 32'h0, "inst_valid during reset");
    compare(ar.addr, START_PC, "read address during reset");
    apply_reset(1'b0);
    while (ar_log.size() == 0) begin
      @(negedge clk);
    end
    compare(ar_log[0], START_PC, "first read address");
    report_test("reset state", e0);
  endtask

  task automatic test_sequential;
    int e0;
    e0 = errors;
    apply_reset(1'b0);
    run_pcs(START_PC, 64);
    report_test("sequential fetch", e0);
  endtask

  task automatic test_prefetch_depth;
    int e0;
    e0 = errors;
    apply_reset(1'b0);
    // window far longer than four reads take
    repeat (80) @(negedge clk);
    compare(32'(ar_log.size()), 32'd4, "number of line reads with pc held");
    for (int i = 0; i < ar_log.size() && i < 4; i++) begin
      compare(ar_log[i], START_PC + 32'(16 * i), $sformatf("prefetch address %0d", i));
    end
    repeat (4) begin
      @(negedge clk);
      compare(32'(ar.valid), 32'h0, "ar valid with full queue");
    end
    report_test("prefetch depth", e0);
  endtask

  task automatic test_jump_flush;
    int e0;
    e0 = errors;
    apply_reset(1'b1);
    // flush while the slow first read is still out
    @(negedge clk);
    while (!r_ready) begin
      @(negedge clk);
    end
    jump_to(JUMP_PC);
    while (ar_log.size() == 0) begin
      @(negedge clk);
    end
    compare(ar_log[0], {JUMP_PC[31:4], 4'b0000}, "read address after flush");
    wait_inst_valid();
    compare(inst, word_hash(JUMP_PC), "first instruction after flush");
    compare(32'(inst_fault), 32'h0, "fault after flush");
    report_test("jump flush", e0);
  endtask

  task automatic test_fault_window;
    int e0;
    e0 = errors;
    apply_reset(1'b0);
    wait_inst_valid();
    // two lines before the window, through it, and four lines after
    jump_to(ERR_LO - 32'h20);
    run_pcs(ERR_LO - 32'h20, 40);
    report_test("fault report", e0);
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    rst_n = 1'b1;
    flush = 1'b0;
    slow = 1'b0;
    pc = START_PC;
    cycles = 0;
    errors = 0;
    checks = 0;
    tests = 0;

    test_reset();
    test_sequential();
    test_prefetch_depth();
    test_jump_flush();
    test_fault_window();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/line_slave.sv ====
`timescale 1ns/10ps

module line_slave (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    slow_i,
  input  line_bus_pkg::ar_req_t   ar_i,
  output logic                    ar_ready_o,
  output line_bus_pkg::r_rsp_t    r_o,
  input  logic                    r_ready_i
);

  `include "mem_model.svh"

  logic [31:0] rng;
  logic [4:0]  wait_q;
  logic [31:0] addr_q;
  logic        busy_q;

  // latency 0 to 3 from two LFSR bits, or a long one for a slow read
  task automatic draw_wait(input logic slow);
    logic [1:0] bits;
    rng = lfsr_step(rng);
    bits[0] = rng[0];
    rng = lfsr_step(rng);
    bits[1] = rng[0];
    wait_q <= slow ? 5'd20 : {3'b000, bits};
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      rng = LFSR_SEED;
      ar_ready_o <= 1'b0;
      wait_q <= '0;
      addr_q <= '0;
      busy_q <= 1'b0;
      r_o <= '0;
    end else if (!busy_q) begin
      // ====================
      // address phase
      // ====================
      if (ar_i.valid && ar_ready_o) begin
        ar_ready_o <= 1'b0;
        addr_q <= ar_i.addr;
        busy_q <= 1'b1;
        draw_wait(slow_i);
      end else if (ar_i.valid) begin
        if (wait_q == 5'd0) begin
          ar_ready_o <= 1'b1;
        end else begin
          wait_q <= wait_q - 5'd1;
        end
      end
    end else begin
      // ====================
      // data phase
      // ====================
      if (r_o.valid && r_ready_i) begin
        r_o.valid <= 1'b0;
        busy_q <= 1'b0;
        draw_wait(1'b0);
      end else if (!r_o.valid) begin
        if (wait_q == 5'd0) begin
          r_o.valid <= 1'b1;
          r_o.data <= line_data(addr_q);
          r_o.resp <= in_err_window(addr_q) ? line_bus_pkg::RESP_SLVERR
                                            : line_bus_pkg::RESP_OKAY;
        end else begin
          wait_q <= wait_q - 5'd1;
        end
      end
    end
  end

endmodule

// ==== hdl/fetch_frontend.sv ====
`timescale 1ns/10ps

module fetch_frontend (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  fetch_pkg::pc_t          pc_i,
  output line_bus_pkg::ar_req_t   ar_o,
  input  logic                    ar_ready_i,
  input  line_bus_pkg::r_rsp_t    r_i,
  output logic                    r_ready_o,
  output logic                    inst_valid_o,
  output logic [31:0]             inst_o,
  output logic                    inst_fault_o
);

  // requester to queue
  logic                    push;
  fetch_pkg::queue_entry_t push_entry;

  // queue status
  logic                    q_full;
  logic                    q_empty;
  fetch_pkg::queue_count_t q_count;

  // selector to queue and requester
  logic                    pop;
  fetch_pkg::queue_entry_t head;
  fetch_pkg::line_addr_t   base_line;

  line_requester u_line_requester (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .base_line_i  (base_line),
    .q_full_i     (q_full),
    .q_count_i    (q_count),
    .ar_o         (ar_o),
    .ar_ready_i   (ar_ready_i),
    .r_i          (r_i),
    .r_ready_o    (r_ready_o),
    .push_o       (push),
    .push_entry_o (push_entry)
  );

  line_queue u_line_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (pop),
    .head_o       (head),
    .empty_o      (q_empty),
    .full_o       (q_full),
    .count_o      (q_count)
  );

  inst_select u_inst_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc_i),
    .q_empty_i    (q_empty),
    .head_i       (head),
    .pop_o        (pop),
    .base_line_o  (base_line),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_fault_o (inst_fault_o)
  );

endmodule

// ==== hdl/inst_select.sv ====
`timescale 1ns/10ps

module inst_select (
  input  logic                      clk,
  input  logic                      rst_n,
  input  fetch_pkg::pc_t            pc_i,
  input  logic                      q_empty_i,
  input  fetch_pkg::queue_entry_t   head_i,
  output logic                      pop_o,
  output fetch_pkg::line_addr_t     base_line_o,
  output logic                      inst_valid_o,
  output logic [31:0]               inst_o,
  output logic                      inst_fault_o
);

  // line the queue head stands for
  fetch_pkg::line_addr_t base_line_q;

  fetch_pkg::line_addr_t pc_line;
  logic                  line_hit;
  logic [1:0]            word_sel;

  // ====================
  // line tracking
  // ====================

  assign pc_line  = pc_i[31:4];
  assign line_hit = (pc_line == base_line_q);

  // pc left the head line, so the head is used up
  assign pop_o = !line_hit && !q_empty_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      base_line_q <= fetch_pkg::RESET_LINE;
    end else if (!line_hit) begin
      base_line_q <= pc_line;
    end
  end

  assign base_line_o = base_line_q;

  // ====================
  // instruction word
  // ====================

  assign word_sel = pc_i[3:2];

  always_comb begin
    case (word_sel)
      2'd0:    inst_o = head_i.line[31:0];
      2'd1:    inst_o = head_i.line[63:32];
      2'd2:    inst_o = head_i.line[95:64];
      default: inst_o = head_i.line[127:96];
    endcase
  end

  // stalled core keeps pc still, head stays valid
  assign inst_valid_o = line_hit && !q_empty_i;

  // error mark of the whole line
  assign inst_fault_o = inst_valid_o && head_i.fault;

endmodule

// ==== hdl/line_queue.sv ====
`timescale 1ns/10ps

module line_queue (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  input  logic                      push_i,
  input  fetch_pkg::queue_entry_t   push_entry_i,
  input  logic                      pop_i,
  output fetch_pkg::queue_entry_t   head_o,
  output logic                      empty_o,
  output logic                      full_o,
  output fetch_pkg::queue_count_t   count_o
);

  localparam int PTR_MSB = fetch_pkg::QUEUE_PTR_W - 1;

  fetch_pkg::queue_entry_t mem [fetch_pkg::QUEUE_DEPTH];

  logic [PTR_MSB:0]        wr_ptr_q;
  logic [PTR_MSB:0]        rd_ptr_q;
  fetch_pkg::queue_count_t count_q;

  logic push_ok;
  logic pop_ok;

  // ====================
  // status
  // ====================

  // same index, wrap bit decides
  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q == {~rd_ptr_q[PTR_MSB], rd_ptr_q[PTR_MSB-1:0]});
  assign count_o = count_q;

  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  assign head_o = mem[rd_ptr_q[PTR_MSB-1:0]];

  // ====================
  // storage
  // ====================

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr_q[PTR_MSB-1:0]] <= push_entry_i;
    end
  end

  // pointers and count, flush over push
  always_ff @(posedge clk) begin
    if (rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== hdl/line_requester.sv ====
`timescale 1ns/10ps

module line_requester (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  input  fetch_pkg::line_addr_t     base_line_i,
  input  logic                      q_full_i,
  input  fetch_pkg::queue_count_t   q_count_i,
  output line_bus_pkg::ar_req_t     ar_o,
  input  logic                      ar_ready_i,
  input  line_bus_pkg::r_rsp_t      r_i,
  output logic                      r_ready_o,
  output logic                      push_o,
  output fetch_pkg::queue_entry_t   push_entry_o
);

  line_bus_pkg::req_state_e state_q;
  line_bus_pkg::req_state_e state_d;

  fetch_pkg::line_addr_t next_line;
  logic [31:0]           fresh_addr;
  logic [31:0]           ar_addr;
  logic                  ar_valid;
  logic                  ar_hs;
  logic                  r_hs;

  // address held while the memory stalls the ar channel
  logic        ar_hold_q;
  logic [31:0] ar_addr_q;

  // response in flight belongs to a line before a flush
  logic drop_q;

  // ====================
  // read address
  // ====================

  // next line to fetch sits right behind the buffered ones
  assign next_line  = base_line_i + fetch_pkg::line_addr_t'(q_count_i);
  assign fresh_addr = {next_line, 4'b0000};
  assign ar_addr    = ar_hold_q ? ar_addr_q : fresh_addr;

  // no request while reset is held
  assign ar_valid = !rst_n && (state_q == line_bus_pkg::REQ_IDLE) && !q_full_i && !push_o;
  assign ar_hs    = ar_valid && ar_ready_i;

  assign ar_o = '{valid: ar_valid, addr: ar_addr};

  always_ff @(posedge clk) begin
    if (rst_n) begin
      ar_hold_q <= 1'b0;
    end else begin
      ar_hold_q <= ar_valid && !ar_ready_i;
    end
  end

  always_ff @(posedge clk) begin
    ar_addr_q <= ar_addr;
  end

  // ====================
  // read data
  // ====================

  assign r_ready_o = (state_q == line_bus_pkg::REQ_WAIT);
  assign r_hs      = r_i.valid && r_ready_o;

  // stale lines are thrown away here
  assign push_o             = r_hs && !drop_q;
  assign push_entry_o.line  = r_i.data;
  assign push_entry_o.fault = (r_i.resp != line_bus_pkg::RESP_OKAY);

  // ====================
  // FSM
  // ====================

  always_comb begin
    state_d = state_q;
    case (state_q)
      line_bus_pkg::REQ_IDLE: begin
        if (ar_hs) begin
          state_d = line_bus_pkg::REQ_WAIT;
        end
      end
      line_bus_pkg::REQ_WAIT: begin
        // a flush does not cut the read short since the line still comes back
        if (r_hs) begin
          state_d = line_bus_pkg::REQ_IDLE;
        end
      end
      default: begin
        state_d = line_bus_pkg::REQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= line_bus_pkg::REQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // flush while an address is out or still offered marks its line stale
  always_ff @(posedge clk) begin
    if (rst_n) begin
      drop_q <= 1'b0;
    end else if (r_hs) begin
      drop_q <= 1'b0;
    end else if (flush_i && (r_ready_o || ar_valid)) begin
      drop_q <= 1'b1;
    end
  end

endmodule

// ==== hdl/line_bus_pkg.sv ====
package line_bus_pkg;

  // ====================
  // read channel
  // ====================

  // read response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // read address, from the requester
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } ar_req_t;

  // read data, from the memory
  typedef struct packed {
    logic            valid;
    fetch_pkg::line_t data;
    resp_e           resp;
  } r_rsp_t;

  // ====================
  // requester FSM
  // ====================

  // one read outstanding at most
  typedef enum logic {
    REQ_IDLE = 1'b0,
    REQ_WAIT = 1'b1
  } req_state_e;

endpackage

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

  // ====================
  // program counter and line types
  // ====================

  // byte address of one instruction
  typedef logic [31:0] pc_t;

  // pc without the 4 offset bits
  typedef logic [27:0] line_addr_t;

  // four 32-bit instructions, lowest address in bits 31:0
  typedef logic [127:0] line_t;

  // line fetched after reset, from 32'h8000_0000
  localparam line_addr_t RESET_LINE = 28'h800_0000;

  // ====================
  // line queue
  // ====================

  localparam int QUEUE_DEPTH = 4;

  // two index bits plus a wrap bit
  localparam int QUEUE_PTR_W = 3;

  // occupancy 0 to 4
  typedef logic [2:0] queue_count_t;

  // one buffered line and its error mark
  typedef struct packed {
    line_t line;
    logic  fault;
  } queue_entry_t;

endpackage
